// ==== hw/soc_pkg.sv ====
package soc_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int WB_AW = 32;
  localparam int WB_DW = 32;
  localparam int WB_SW = 4;   // One select per byte lane

  typedef logic [WB_AW-1:0] wb_addr_t;
  typedef logic [WB_DW-1:0] wb_data_t;
  typedef logic [WB_SW-1:0] wb_sel_t;

  ////////////////////////////////////////
  // Address map
  ////////////////////////////////////////
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = 8;   // Word index bits

  localparam wb_addr_t MEM_BASE  = 32'h0000_0000;
  localparam wb_addr_t GPIO_BASE = 32'h9100_0000;  // 16 byte window

  typedef enum logic [1:0] {
    SEL_MEM,
    SEL_GPIO,
    SEL_NONE
  } slave_sel_e;

  ////////////////////////////////////////
  // GPIO block
  ////////////////////////////////////////
  localparam int GPIO_W = 8;

  typedef logic [GPIO_W-1:0] gpio_t;

  // Word offsets inside the GPIO window
  localparam logic [1:0] GPIO_REG_OUT  = 2'd0;
  localparam logic [1:0] GPIO_REG_IN   = 2'd1;
  localparam logic [1:0] GPIO_REG_MASK = 2'd2;
  localparam logic [1:0] GPIO_REG_STAT = 2'd3;

  // Processor interrupt lines, same order as the full SoC
  localparam int IRQ_UART = 2;
  localparam int IRQ_GPIO = 3;
  localparam int IRQ_MPI  = 4;

  typedef logic [31:0] irq_vec_t;

endpackage

// ==== hw/soc_tile.sv ====
`timescale 1ns/100ps

module soc_tile import soc_pkg::*; (
  input  logic     wb_clk_i,
  input  logic     reset_i,
  input  wb_addr_t adr_i,
  input  wb_data_t dat_i,
  input  wb_sel_t  sel_i,
  input  logic     we_i,
  input  logic     cyc_i,
  input  logic     stb_i,
  output wb_data_t dat_o,
  output logic     ack_o,
  output logic     err_o,
  input  gpio_t    gpio_i,
  output gpio_t    gpio_o,
  output irq_vec_t irq_o
);

  logic gpio_irq;

  wb_bus_if host_bus ();
  wb_bus_if mem_bus ();
  wb_bus_if gpio_bus ();

  ////////////////////////////////////////
  // Host port
  ////////////////////////////////////////
  assign host_bus.adr   = adr_i;
  assign host_bus.dat_w = dat_i;
  assign host_bus.sel   = sel_i;
  assign host_bus.we    = we_i;
  assign host_bus.cyc   = cyc_i;
  assign host_bus.stb   = stb_i;

  assign dat_o = host_bus.dat_r;
  assign ack_o = host_bus.ack;
  assign err_o = host_bus.err;

  ////////////////////////////////////////
  // Data bus and slaves
  ////////////////////////////////////////
  wb_addr_decoder u_decoder (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .host     (host_bus.slave),
    .mem      (mem_bus.master),
    .gpio     (gpio_bus.master)
  );

  wb_spram u_spram (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .bus      (mem_bus.slave)
  );

  wb_gpio u_gpio (
    .wb_clk_i (wb_clk_i),
    .reset_i  (reset_i),
    .bus      (gpio_bus.slave),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .irq_o    (gpio_irq)
  );

  // Processor interrupt vector
  always_comb begin
    irq_o           = '0;
    irq_o[IRQ_UART] = 1'b0;   // No UART in this tile
    irq_o[IRQ_GPIO] = gpio_irq;
    irq_o[IRQ_MPI]  = 1'b0;   // No MPI either
  end

endmodule

// ==== hw/wb_addr_decoder.sv ====
`timescale 1ns/100ps

module wb_addr_decoder import soc_pkg::*; (
  input logic     wb_clk_i,
  input logic     reset_i,
  wb_bus_if.slave  host,
  wb_bus_if.master mem,
  wb_bus_if.master gpio
);

  slave_sel_e slave_sel;
  logic       host_req;
  logic       err_q;

  assign host_req = host.cyc & host.stb;

  ////////////////////////////////////////
  // Address compare
  ////////////////////////////////////////
  always_comb begin
    if (host.adr[WB_AW-1:MEM_AW+2] == MEM_BASE[WB_AW-1:MEM_AW+2]) begin
      slave_sel = SEL_MEM;
    end else if (host.adr[WB_AW-1:4] == GPIO_BASE[WB_AW-1:4]) begin
      slave_sel = SEL_GPIO;
    end else begin
      slave_sel = SEL_NONE;
    end
  end

  ////////////////////////////////////////
  // Request fan-out
  ////////////////////////////////////////
  assign mem.adr   = host.adr;
  assign mem.dat_w = host.dat_w;
  assign mem.sel   = host.sel;
  assign mem.we    = host.we;
  assign mem.cyc   = host.cyc;
  assign mem.stb   = host.stb & (slave_sel == SEL_MEM);   // Only the target sees stb

  assign gpio.adr   = host.adr;
  assign gpio.dat_w = host.dat_w;
  assign gpio.sel   = host.sel;
  assign gpio.we    = host.we;
  assign gpio.cyc   = host.cyc;
  assign gpio.stb   = host.stb & (slave_sel == SEL_GPIO);

  // Unmapped cycle ends one clock later with err
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= host_req & (slave_sel == SEL_NONE) & ~err_q;
    end
  end

  ////////////////////////////////////////
  // Response mux
  ////////////////////////////////////////
  always_comb begin
    case (slave_sel)
      SEL_MEM: begin
        host.dat_r = mem.dat_r;
        host.ack   = mem.ack;
        host.err   = mem.err;
      end
      SEL_GPIO: begin
        host.dat_r = gpio.dat_r;
        host.ack   = gpio.ack;
        host.err   = gpio.err;
      end
      default: begin
        host.dat_r = '0;       // Nothing to read back
        host.ack   = 1'b0;
        host.err   = err_q;
      end
    endcase
  end

endmodule

// ==== hw/wb_bus_if.sv ====
`timescale 1ns/100ps

interface wb_bus_if import soc_pkg::*; ();

  // Request side, owned by the master
  wb_addr_t adr;
  wb_data_t dat_w;
  wb_sel_t  sel;
  logic     we;
  logic     cyc;
  logic     stb;

  // Response side, owned by the slave
  wb_data_t dat_r;
  logic     ack;
  logic     err;

  modport master (
    output adr, dat_w, sel, we, cyc, stb,
    input  dat_r, ack, err
  );

  modport slave (
    input  adr, dat_w, sel, we, cyc, stb,
    output dat_r, ack, err
  );

endinterface

// ==== hw/wb_gpio.sv ====
`timescale 1ns/100ps

module wb_gpio import soc_pkg::*; (
  input  logic    wb_clk_i,
  input  logic    reset_i,
  wb_bus_if.slave bus,
  input  gpio_t   gpio_i,
  output gpio_t   gpio_o,
  output logic    irq_o
);

  gpio_t      out_q;
  gpio_t      sync1_q;
  gpio_t      sync2_q;
  gpio_t      prev_q;
  gpio_t      rise_q;
  gpio_t      mask_q;
  gpio_t      stat_q;
  wb_data_t   rd_q;
  wb_data_t   rd_mux;
  logic       ack_q;
  logic       req;
  logic       wr_en;
  logic [1:0] reg_idx;

  assign req     = bus.cyc & bus.stb & ~ack_q;
  assign wr_en   = req & bus.we & bus.sel[0];   // Registers sit in byte lane 0
  assign reg_idx = bus.adr[3:2];

  ////////////////////////////////////////
  // Pin input path
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
      rise_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      rise_q  <= sync2_q & ~prev_q;   // 0 to 1 seen on synchronized pin
    end
  end

  ////////////////////////////////////////
  // Control registers
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      out_q  <= '0;
      mask_q <= '0;
      stat_q <= '0;
    end else begin
      if (wr_en && reg_idx == GPIO_REG_OUT) begin
        out_q <= bus.dat_w[GPIO_W-1:0];
      end
      if (wr_en && reg_idx == GPIO_REG_MASK) begin
        mask_q <= bus.dat_w[GPIO_W-1:0];
      end
      // Write 1 clears, a new edge in the same cycle keeps its bit
      if (wr_en && reg_idx == GPIO_REG_STAT) begin
        stat_q <= (stat_q & ~bus.dat_w[GPIO_W-1:0]) | rise_q;
      end else begin
        stat_q <= stat_q | rise_q;
      end
    end
  end

  // Read data, zero extended
  always_comb begin
    case (reg_idx)
      GPIO_REG_OUT:  rd_mux = wb_data_t'(out_q);
      GPIO_REG_IN:   rd_mux = wb_data_t'(sync2_q);
      GPIO_REG_MASK: rd_mux = wb_data_t'(mask_q);
      default:       rd_mux = wb_data_t'(stat_q);
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      rd_q <= rd_mux;
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;
  assign bus.dat_r = rd_q;

  assign gpio_o = out_q;
  assign irq_o  = |(stat_q & mask_q);   // Any enabled pending edge

endmodule

// ==== hw/wb_spram.sv ====
`timescale 1ns/100ps

module wb_spram import soc_pkg::*; (
  input logic    wb_clk_i,
  input logic    reset_i,
  wb_bus_if.slave bus
);

  wb_data_t          mem_q [MEM_WORDS];
  wb_data_t          rd_q;
  logic              ack_q;
  logic              req;
  logic [MEM_AW-1:0] word_idx;

  // New request only while no termination is pending
  assign req      = bus.cyc & bus.stb & ~ack_q;
  assign word_idx = bus.adr[MEM_AW+1:2];

  ////////////////////////////////////////
  // Storage array
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (req & bus.we) begin
      for (int b = 0; b < WB_SW; b++) begin
        if (bus.sel[b]) begin
          mem_q[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];   // Byte lane b
        end
      end
    end
  end

  // Read word lines up with ack
  always_ff @(posedge wb_clk_i) begin
    if (req & ~bus.we) begin
      rd_q <= mem_q[word_idx];
    end
  end

  ////////////////////////////////////////
  // Termination
  ////////////////////////////////////////
  always_ff @(posedge wb_clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;   // Single cycle, one clock after stb
    end
  end

  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;   // Every word in the window exists
  assign bus.dat_r = rd_q;

endmodule

// ==== tb.f ====
+incdir+test
hw/soc_pkg.sv
hw/wb_bus_if.sv
hw/wb_addr_decoder.sv
hw/wb_spram.sv
hw/wb_gpio.sv
hw/soc_tile.sv
test/tb_soc_tile.sv

// ==== test/soc_model.svh ====
`ifndef SOC_MODEL_SVH
`define SOC_MODEL_SVH

////////////////////////////////////////
// Reference state
////////////////////////////////////////
wb_data_t model_mem [MEM_WORDS];
gpio_t    model_out;
gpio_t    model_pins;   // Last value driven on gpio_i
gpio_t    model_mask;
gpio_t    model_stat;   // Sticky rising edges

function automatic bit in_mem_window(wb_addr_t a);
  return (a >= MEM_BASE) && (a < MEM_BASE + MEM_WORDS * 4);
endfunction

function automatic bit in_gpio_window(wb_addr_t a);
  return (a >= GPIO_BASE) && (a < GPIO_BASE + 16);
endfunction

// Byte lanes with sel set take the new data
function automatic wb_data_t merge_bytes(wb_data_t old_w, wb_data_t new_w, wb_sel_t sel);
  wb_data_t res;
  res = old_w;
  for (int b = 0; b < WB_SW; b++) begin
    if (sel[b]) begin
      res[8*b +: 8] = new_w[8*b +: 8];
    end
  end
  return res;
endfunction

task automatic model_mem_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s);
  model_mem[(a - MEM_BASE) / 4] = merge_bytes(model_mem[(a - MEM_BASE) / 4], d, s);
endtask

function automatic wb_data_t expect_mem(wb_addr_t a);
  return model_mem[(a - MEM_BASE) / 4];
endfunction

////////////////////////////////////////
// GPIO registers
////////////////////////////////////////
task automatic model_drive_pins(input gpio_t v);
  model_stat = model_stat | (v & ~model_pins);   // Pins that rose
  model_pins = v;
endtask

task automatic model_gpio_write(input logic [1:0] r, input wb_data_t d);
  case (r)
    GPIO_REG_OUT:  model_out = d[GPIO_W-1:0];
    GPIO_REG_MASK: model_mask = d[GPIO_W-1:0];
    GPIO_REG_STAT: model_stat = model_stat & ~d[GPIO_W-1:0];   // Write 1 clears
    default: ;   // IN is read only
  endcase
endtask

function automatic wb_data_t expect_gpio(logic [1:0] r);
  case (r)
    GPIO_REG_OUT:  return {{(WB_DW-GPIO_W){1'b0}}, model_out};
    GPIO_REG_IN:   return {{(WB_DW-GPIO_W){1'b0}}, model_pins};
    GPIO_REG_MASK: return {{(WB_DW-GPIO_W){1'b0}}, model_mask};
    default:       return {{(WB_DW-GPIO_W){1'b0}}, model_stat};
  endcase
endfunction

function automatic irq_vec_t expect_irq();
  irq_vec_t v;
  v = '0;
  v[IRQ_GPIO] = |(model_stat & model_mask);
  return v;
endfunction

`endif

// ==== test/tb_soc_tile.sv ====
`timescale 1ns/100ps

module tb_soc_tile import soc_pkg::*; ();

  localparam int NUM_RAM_WR  = 200;
  localparam int NUM_BAD     = 16;
  localparam int NUM_GPIO    = 16;
  localparam int PIN_SETTLE  = 5;    // Synchronizer and edge register plus one spare
  localparam int TERM_WAIT   = 8;
  // Transactions in the fill pass, the random RAM test and the smaller tests
  localparam int NUM_TXN     = MEM_WORDS + 2 * NUM_RAM_WR + 136;
  localparam int CYCLE_LIMIT = NUM_TXN * 4 + 400;

  logic     wb_clk_i;
  logic     reset_i;
  wb_addr_t adr_i;
  wb_data_t dat_i;
  wb_sel_t  sel_i;
  logic     we_i;
  logic     cyc_i;
  logic     stb_i;
  wb_data_t dat_o;
  logic     ack_o;
  logic     err_o;
  gpio_t    gpio_i;
  gpio_t    gpio_o;
  irq_vec_t irq_o;

  integer seed        = 38058;
  int     cycle_count = 0;
  int     error_count = 0;
  int     errs_before = 0;
  int     pass_tests  = 0;
  int     fail_tests  = 0;

  `include "soc_model.svh"

  soc_tile UUT (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #20 wb_clk_i = ~wb_clk_i;
  end

  always @(posedge wb_clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////
  task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_irq(input string name, input irq_vec_t got, input irq_vec_t exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Values are {ack, err}
  task automatic check_term(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  ////////////////////////////////////////
  // Bus tasks start on a falling edge
  ////////////////////////////////////////
  task automatic bus_cycle(input wb_addr_t a, input wb_data_t d, input wb_sel_t s,
                           input logic we, output wb_data_t rd, output logic [1:0] term);
    int waited;
    adr_i = a;
    dat_i = d;
    sel_i = s;
    we_i  = we;
    cyc_i = 1'b1;
    stb_i = 1'b1;
    @(negedge wb_clk_i);
    waited = 1;
    while (!(ack_o || err_o) && waited < TERM_WAIT) begin
      @(negedge wb_clk_i);
      waited++;
    end
    term = {ack_o, err_o};
    rd   = dat_o;
    if (!(ack_o || err_o)) begin
      report_error($sformatf("cycle to %h got no ack or err", a));
    end else if (waited != 1) begin
      report_error($sformatf("cycle to %h ended after %0d clocks, not 1", a, waited));
    end
    if (ack_o && err_o) begin
      report_error($sformatf("cycle to %h got ack and err together", a));
    end
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    @(negedge wb_clk_i);   // Idle clock between cycles
    if (ack_o || err_o) begin
      report_error($sformatf("termination for %h stayed high a second clock", a));
    end
  endtask

  task automatic bus_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s,
                           output logic [1:0] term);
    wb_data_t unused;
    bus_cycle(a, d, s, 1'b1, unused, term);
  endtask

  task automatic bus_read(input wb_addr_t a, output wb_data_t rd, output logic [1:0] term);
    bus_cycle(a, '0, '1, 1'b0, rd, term);
  endtask

  function automatic wb_addr_t random_ram_addr();
    return MEM_BASE + wb_addr_t'(($unsigned($random(seed)) % MEM_WORDS) * 4);
  endfunction

  function automatic wb_addr_t random_unmapped_addr();
    wb_addr_t a;
    a = $random(seed) & ~32'h3;
    while (in_mem_window(a) || in_gpio_window(a)) begin
      a = $random(seed) & ~32'h3;
    end
    return a;
  endfunction

  function automatic wb_addr_t gpio_addr(logic [1:0] r);
    return GPIO_BASE + wb_addr_t'(r) * 4;
  endfunction

  task automatic finish_test(input string name);
    if (error_count == errs_before) begin
      pass_tests++;
      $display("Test %s passed", name);
    end else begin
      fail_tests++;
      $display("Test %s failed with %0d errors", name, error_count - errs_before);
    end
    errs_before = error_count;
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  task automatic ram_test();
    wb_addr_t   a;
    wb_data_t   d;
    wb_data_t   rd;
    wb_sel_t    s;
    logic [1:0] term;
    for (int i = 0; i < MEM_WORDS; i++) begin   // Fill pass
      a = MEM_BASE + wb_addr_t'(i * 4);
      d = $random(seed);
      bus_write(a, d, '1, term);
      model_mem_write(a, d, '1);
    end
    for (int i = 0; i < NUM_RAM_WR; i++) begin
      a = random_ram_addr();
      d = $random(seed);
      s = $random(seed);
      bus_write(a, d, s, term);
      check_term("ram write term", term, 2'b10);
      model_mem_write(a, d, s);
      if ($random(seed) & 1) begin
        a = random_ram_addr();
        bus_read(a, rd, term);
        check_term("ram read term", term, 2'b10);
        check_data("dat_o", rd, expect_mem(a));
      end
    end
    finish_test("ram_random");
  endtask

  task automatic unmapped_test();
    wb_addr_t   a;
    wb_data_t   rd;
    logic [1:0] term;
    for (int i = 0; i < NUM_BAD; i++) begin
      a = random_unmapped_addr();
      if (i % 2 == 0) begin
        bus_write(a, $random(seed), '1, term);
      end else begin
        bus_read(a, rd, term);
      end
      check_term("unmapped term", term, 2'b01);
      a = MEM_BASE + (a % (MEM_WORDS * 4));   // RAM word with the same low bits
      bus_read(a, rd, term);
      check_data("dat_o after unmapped", rd, expect_mem(a));
    end
    finish_test("unmapped");
  endtask

  task automatic gpio_out_test();
    wb_data_t   d;
    wb_data_t   rd;
    logic [1:0] term;
    for (int i = 0; i < NUM_GPIO; i++) begin
      d = $random(seed);
      bus_write(gpio_addr(GPIO_REG_OUT), d, '1, term);
      check_term("gpio write term", term, 2'b10);
      model_gpio_write(GPIO_REG_OUT, d);
      check_gpio("gpio_o", gpio_o, model_out);
      bus_read(gpio_addr(GPIO_REG_OUT), rd, term);
      check_data("dat_o out reg", rd, expect_gpio(GPIO_REG_OUT));
    end
    finish_test("gpio_out");
  endtask

  task automatic drive_pins(input gpio_t v);
    gpio_i = v;
    model_drive_pins(v);
    repeat (PIN_SETTLE) @(negedge wb_clk_i);
  endtask

  task automatic gpio_in_test();
    wb_data_t   d;
    wb_data_t   rd;
    logic [1:0] term;
    for (int i = 0; i < NUM_GPIO; i++) begin
      drive_pins($random(seed));
      bus_read(gpio_addr(GPIO_REG_IN), rd, term);
      check_data("dat_o in reg", rd, expect_gpio(GPIO_REG_IN));
      bus_read(gpio_addr(GPIO_REG_STAT), rd, term);
      check_data("dat_o stat reg", rd, expect_gpio(GPIO_REG_STAT));
      // Clear the seen edges so the next pin value starts from zero status
      d = expect_gpio(GPIO_REG_STAT);
      bus_write(gpio_addr(GPIO_REG_STAT), d, '1, term);
      model_gpio_write(GPIO_REG_STAT, d);
    end
    finish_test("gpio_in");
  endtask

  task automatic gpio_irq_test();
    wb_data_t   d;
    wb_data_t   rd;
    logic [1:0] term;
    for (int i = 0; i < NUM_GPIO / 2; i++) begin
      d = $random(seed);
      bus_write(gpio_addr(GPIO_REG_MASK), d, '1, term);
      model_gpio_write(GPIO_REG_MASK, d);
      drive_pins('0);
      drive_pins($random(seed));   // Every set bit is a rising pin
      check_irq("irq_o", irq_o, expect_irq());
      d = {{(WB_DW-GPIO_W){1'b0}}, model_stat};
      bus_write(gpio_addr(GPIO_REG_STAT), d, '1, term);
      model_gpio_write(GPIO_REG_STAT, d);
      check_irq("irq_o after clear", irq_o, expect_irq());
      bus_read(gpio_addr(GPIO_REG_STAT), rd, term);
      check_data("dat_o stat reg", rd, expect_gpio(GPIO_REG_STAT));
    end
    finish_test("gpio_irq");
  endtask

  initial begin
    reset_i    = 1'b1;
    adr_i      = '0;
    dat_i      = '0;
    sel_i      = '0;
    we_i       = 1'b0;
    cyc_i      = 1'b0;
    stb_i      = 1'b0;
    gpio_i     = '0;
    model_out  = '0;
    model_pins = '0;
    model_mask = '0;
    model_stat = '0;
    repeat (2) @(negedge wb_clk_i);
    reset_i = 1'b0;
    @(negedge wb_clk_i);

    check_term("ack_o/err_o", {ack_o, err_o}, 2'b00);
    check_gpio("gpio_o", gpio_o, '0);
    check_irq("irq_o", irq_o, '0);
    finish_test("reset_values");

    ram_test();
    unmapped_test();
    gpio_out_test();
    gpio_in_test();
    gpio_irq_test();

    $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, error_count);
    if (fail_tests == 0 && error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
